//--- build.f
src/sync_timing_pkg.sv
src/sync_types_pkg.sv
src/sync_polarity.sv
src/csync_gen.sv
src/sync_conditioner.sv
tests/sync_conditioner_chk.sv
tests/sync_monitor.sv
tests/tb_sync_conditioner.sv

//--- Makefile
# Verilator build and run for the sync conditioner

TOP := tb_sync_conditioner

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

# The run passes only when the pass line shows up in the output
sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -o $(TOP)
	out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

//--- tests/tb_sync_conditioner.sv
// Testbench for the sync conditioner
// Plays rows of sync timings into the DUT while sync_monitor checks the output

`timescale 1ns/10ps

module tb_sync_conditioner;

	typedef struct packed {
		logic [15:0] period;
		logic [15:0] hs_width;
		logic        hs_low;
		logic [15:0] lines;
		logic [15:0] vs_lines;
		logic        vs_low;
		logic        csync_en;
	} row_t;

	localparam int  NUM_ROWS = 5;
	localparam int  FRAMES = 4;
	localparam real CLK_PERIOD = 4.0;

	logic                       clk;
	logic                       resetd;
	sync_types_pkg::sync_pair_t dut_in;
	logic                       csync_en;
	sync_types_pkg::sync_out_t  dut_out;
	logic                       start;
	logic                       table_ready = 1'b0;
	row_t                       cur;
	row_t                       rows [NUM_ROWS];
	int                         tests_done;
	int                         tests_failed;
	int                         errors;

	sync_conditioner i_sync_conditioner (
		.clk        (clk),
		.resetd     (resetd),
		.i_sync     (dut_in),
		.i_csync_en (csync_en),
		.o_sync     (dut_out)
	);

	sync_monitor i_sync_monitor (
		.clk            (clk),
		.resetd         (resetd),
		.i_start        (start),
		.i_period       (cur.period),
		.i_hs_width     (cur.hs_width),
		.i_lines        (cur.lines),
		.i_vs_lines     (cur.vs_lines),
		.i_csync_en     (csync_en),
		.i_dut_sync     (dut_out),
		.o_tests_done   (tests_done),
		.o_tests_failed (tests_failed),
		.o_errors       (errors)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2.0) clk = ~clk;
	end

	function automatic row_t make_row(input int p, input int w, input bit hl, input int nl,
		input int vl, input bit vlow, input bit en);
		row_t r;
		r = '{period: p[15:0], hs_width: w[15:0], hs_low: hl, lines: nl[15:0],
			vs_lines: vl[15:0], vs_low: vlow, csync_en: en};
		return r;
	endfunction

	////////////////////
	// Stimulus
	////////////////////

	// One row for four frames, sync active at the start of each line and frame
	task automatic play_row(input row_t row);
		int total;
		int x;
		int line;
		total = FRAMES * int'(row.period) * int'(row.lines);
		for (int c = 0; c < total; c++) begin
			@(posedge clk);
			#1;
			x         = c % int'(row.period);
			line      = (c / int'(row.period)) % int'(row.lines);
			cur       = row;
			start     = (c == 0);
			csync_en  = row.csync_en;
			dut_in.hs = (x < int'(row.hs_width)) ^ row.hs_low;
			dut_in.vs = (line < int'(row.vs_lines)) ^ row.vs_low;
		end
	endtask

	initial begin
		resetd   = 1'b1;
		dut_in   = '0;
		csync_en = 1'b0;
		start    = 1'b0;
		cur      = '0;
		// period, hs width, hs active low, lines, vs lines, vs active low, csync enable
		rows[0] = make_row(40, 6, 0, 12, 2, 0, 0);
		rows[1] = make_row(40, 6, 1, 12, 2, 1, 0);
		rows[2] = make_row(52, 8, 1, 10, 3, 0, 1);
		rows[3] = make_row(36, 4, 0, 14, 2, 1, 1);
		rows[4] = make_row(64, 10, 1, 9, 3, 1, 0);
		table_ready = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		resetd = 1'b0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			play_row(rows[r]);
		end
		wait (tests_done == NUM_ROWS);
		$display("Tests run %0d, failed %0d, errors %0d", tests_done, tests_failed, errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	////////////////////
	// Watchdog
	////////////////////

	// All rows plus reset, with half again as margin
	initial begin : watchdog
		longint cycles;
		realtime limit;
		wait (table_ready);
		cycles = 3;
		for (int r = 0; r < NUM_ROWS; r++) begin
			cycles += FRAMES * int'(rows[r].period) * int'(rows[r].lines);
		end
		limit = cycles * CLK_PERIOD * 1.5;
		#(limit);
		$display("Timeout: the run did not finish within %0d ns", longint'(limit));
		$display("test failed");
		$finish;
	end

endmodule

//--- tests/sync_monitor.sv
// Sync output monitor
// Counts the conditioned pulses over the settled frames of each test

`timescale 1ns/10ps

module sync_monitor (
	input  logic                      clk,
	input  logic                      resetd,
	input  logic                      i_start,
	input  logic [15:0]               i_period,
	input  logic [15:0]               i_hs_width,
	input  logic [15:0]               i_lines,
	input  logic [15:0]               i_vs_lines,
	input  logic                      i_csync_en,
	input  sync_types_pkg::sync_out_t i_dut_sync,
	output int                        o_tests_done,
	output int                        o_tests_failed,
	output int                        o_errors
);

	localparam int FRAMES = 4;
	localparam int SETTLE_FRAMES = 2;

	int   p;
	int   w;
	int   nl;
	int   vl;
	logic en;
	int   cyc;
	int   line;
	int   exp_cs;
	int   cs_tol;
	int   hs_cnt;
	int   cs_cnt;
	int   vs_cnt;
	int   test_errs;
	logic running = 1'b0;
	logic after_rst = 1'b0;
	int   done_cnt = 0;
	int   failed_cnt = 0;
	int   err_cnt = 0;

	assign o_tests_done   = done_cnt;
	assign o_tests_failed = failed_cnt;
	assign o_errors       = err_cnt;

	task automatic report_fail(input string msg);
		$display("[FAIL] time %0d ns, test %0d: %s", $time, done_cnt, msg);
		test_errs++;
		err_cnt++;
	endtask

	////////////////////
	// Sampling
	////////////////////

	// Output for cycle n is stable at the negedge one clock later
	always @(negedge clk) begin
		// Reset cycles and the first cycle after
		if (resetd || after_rst) begin
			if (i_dut_sync !== '0) begin
				report_fail($sformatf("o_sync is %b around reset, expected 000", i_dut_sync));
			end
			after_rst = resetd;
		end
		if (running) begin
			line = (cyc / p) % nl;
			if (cyc >= SETTLE_FRAMES * p * nl) begin
				if (en && (i_dut_sync.hs !== i_dut_sync.cs)) begin
					report_fail($sformatf("line %0d hs %b differs from cs %b", line,
						i_dut_sync.hs, i_dut_sync.cs));
				end
				hs_cnt += (i_dut_sync.hs === 1'b1) ? 1 : 0;
				cs_cnt += (i_dut_sync.cs === 1'b1) ? 1 : 0;
				vs_cnt += (i_dut_sync.vs === 1'b1) ? 1 : 0;
				// End of line
				if (cyc % p == p - 1) begin
					// Serrated lines keep cs high except for one hsync width
					if (line < vl) begin
						exp_cs = p - w;
						cs_tol = 1;
					end else begin
						exp_cs = w;
						cs_tol = 0;
					end
					if (!en && hs_cnt != w) begin
						report_fail($sformatf("line %0d hs high %0d cycles, expected %0d",
							line, hs_cnt, w));
					end
					if (cs_cnt < exp_cs - cs_tol || cs_cnt > exp_cs + cs_tol) begin
						report_fail($sformatf("line %0d cs high %0d cycles, expected %0d",
							line, cs_cnt, exp_cs));
					end
					hs_cnt = 0;
					cs_cnt = 0;
					if (line == nl - 1) begin
						if (vs_cnt != vl * p) begin
							report_fail($sformatf("vs high %0d cycles in frame, expected %0d",
								vs_cnt, vl * p));
						end
						vs_cnt = 0;
					end
				end
			end
			cyc++;
			if (cyc == FRAMES * p * nl) begin
				running = 1'b0;
				if (test_errs == 0) begin
					$display("Test %0d ok: P=%0d W=%0d lines=%0d vs lines=%0d csync=%0d",
						done_cnt, p, w, nl, vl, en);
				end else begin
					$display("Test %0d: %0d mismatches", done_cnt, test_errs);
					failed_cnt++;
				end
				done_cnt++;
			end
		end
		// Row values latched here since the driver moves on before the last check
		if (i_start) begin
			p         = int'(i_period);
			w         = int'(i_hs_width);
			nl        = int'(i_lines);
			vl        = int'(i_vs_lines);
			en        = i_csync_en;
			cyc       = 0;
			hs_cnt    = 0;
			cs_cnt    = 0;
			vs_cnt    = 0;
			test_errs = 0;
			running   = 1'b1;
		end
	end

endmodule

//--- tests/sync_conditioner_chk.sv
// Sync output checker
// Bound into csync_gen, watches the reset state and the hs select

`timescale 1ns/10ps

module sync_conditioner_chk (
	input logic                       clk,
	input logic                       resetd,
	input sync_types_pkg::sync_pair_t i_sync,
	input logic                       i_csync_en,
	input sync_types_pkg::sync_out_t  i_out_sync
);

	// Output register idle once reset has been seen
	a_rst_idle: assert property (@(posedge clk) resetd |=> (i_out_sync == '0))
		else $error("o_sync not all zero on the cycle after reset");

	// Plain normalized hsync on the pin when composite is off
	a_hs_plain: assert property (@(posedge clk) disable iff (resetd)
		!i_csync_en |=> (i_out_sync.hs == $past(i_sync.hs)))
		else $error("o_sync.hs differs from the registered normalized hs");

endmodule

bind csync_gen sync_conditioner_chk i_sync_conditioner_chk (
	.clk        (clk),
	.resetd     (resetd),
	.i_sync     (i_sync),
	.i_csync_en (i_csync_en),
	.i_out_sync (o_sync)
);

//--- src/sync_conditioner.sv
// Video sync conditioner top
// Normalizes hsync and vsync polarity and adds composite sync

`timescale 1ns/10ps

module sync_conditioner (
	input  logic                       clk,
	input  logic                       resetd,
	input  sync_types_pkg::sync_pair_t i_sync,
	input  logic                       i_csync_en,
	output sync_types_pkg::sync_out_t  o_sync
);

	logic                       norm_hs;
	logic                       norm_vs;
	sync_types_pkg::sync_pair_t norm_sync;

	////////////////////
	// Polarity
	////////////////////

	// Horizontal sync to active high
	sync_polarity i_sync_polarity_h (
		.clk    (clk),
		.resetd (resetd),
		.i_sync (i_sync.hs),
		.o_sync (norm_hs)
	);

	// Vertical sync to active high
	sync_polarity i_sync_polarity_v (
		.clk    (clk),
		.resetd (resetd),
		.i_sync (i_sync.vs),
		.o_sync (norm_vs)
	);

	assign norm_sync = '{hs: norm_hs, vs: norm_vs};

	////////////////////
	// Composite sync
	////////////////////

	// Single register stage from input to output
	csync_gen i_csync_gen (
		.clk        (clk),
		.resetd     (resetd),
		.i_sync     (norm_sync),
		.i_csync_en (i_csync_en),
		.o_sync     (o_sync)
	);

endmodule

//--- src/csync_gen.sv
// Composite sync generator
// Serrates hsync during vsync and registers the hs, vs, cs triple

`timescale 1ns/10ps

module csync_gen (
	input  logic                       clk,
	input  logic                       resetd,
	input  sync_types_pkg::sync_pair_t i_sync,
	input  logic                       i_csync_en,
	output sync_types_pkg::sync_out_t  o_sync
);

	logic                  hs_d;
	logic                  hs_rise;
	logic                  hs_fall;
	sync_timing_pkg::cnt_t h_cnt;
	sync_timing_pkg::cnt_t h_cnt_inc;
	sync_timing_pkg::cnt_t hs_len;
	sync_timing_pkg::cnt_t gap_len;
	logic                  ser_hs;
	logic                  ser_hs_nxt;
	logic                  cs_nxt;

	////////////////////
	// Horizontal edges
	////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			hs_d <= 1'b0;
		end else begin
			hs_d <= i_sync.hs;
		end
	end

	assign hs_rise = i_sync.hs & ~hs_d;
	assign hs_fall = ~i_sync.hs & hs_d;

	////////////////////
	// Line measurement
	////////////////////

	// Cycles elapsed since the last hs edge, counting the current one
	assign h_cnt_inc = sync_timing_pkg::sat_inc(h_cnt);

	always_ff @(posedge clk) begin
		if (resetd) begin
			h_cnt <= sync_timing_pkg::CNT_RST;
		end else if (hs_rise || hs_fall) begin
			h_cnt <= sync_timing_pkg::CNT_RST;
		end else begin
			h_cnt <= h_cnt_inc;
		end
	end

	// Pulse width at the fall, remaining line minus width at the rise
	// gap_len is where the serration pulse restarts after the hs fall
	always_ff @(posedge clk) begin
		if (resetd) begin
			hs_len  <= sync_timing_pkg::CNT_RST;
			gap_len <= sync_timing_pkg::CNT_RST;
		end else begin
			if (hs_fall) begin
				hs_len <= h_cnt_inc;
			end
			if (hs_rise) begin
				gap_len <= h_cnt_inc - hs_len;
			end
		end
	end

	////////////////////
	// Serration
	////////////////////

	// Outside vsync the horizontal part is plain hs
	// Inside vsync it drops at each line start and comes back
	// one hsync width before the next line
	always_comb begin
		if (!i_sync.vs) begin
			ser_hs_nxt = i_sync.hs;
		end else if (hs_rise) begin
			ser_hs_nxt = 1'b0;
		end else if (h_cnt_inc == gap_len) begin
			ser_hs_nxt = 1'b1;
		end else begin
			ser_hs_nxt = ser_hs;
		end
	end

	always_ff @(posedge clk) begin
		if (resetd) begin
			ser_hs <= 1'b0;
		end else begin
			ser_hs <= ser_hs_nxt;
		end
	end

	// Inverted horizontal part during vsync gives the serrated interval
	assign cs_nxt = ser_hs_nxt ^ i_sync.vs;

	////////////////////
	// Output register
	////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			o_sync <= sync_types_pkg::SYNC_OUT_IDLE;
		end else begin
			o_sync.vs <= i_sync.vs;
			o_sync.cs <= cs_nxt;
			// Composite on the horizontal pin when enabled
			o_sync.hs <= i_csync_en ? cs_nxt : i_sync.hs;
		end
	end

endmodule

//--- src/sync_polarity.sv
// Sync polarity normalizer
// Measures both phases of one sync and drives the shorter phase high

`timescale 1ns/10ps

module sync_polarity (
	input  logic clk,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);

	logic                  sync_d1;
	logic                  sync_d2;
	logic                  rise;
	logic                  fall;
	sync_timing_pkg::cnt_t phase_cnt;
	sync_timing_pkg::cnt_t low_len;
	sync_timing_pkg::cnt_t high_len;
	logic                  pol;

	////////////////////
	// Input sampling
	////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			sync_d1 <= 1'b0;
			sync_d2 <= 1'b0;
		end else begin
			sync_d1 <= i_sync;
			sync_d2 <= sync_d1;
		end
	end

	// Edges of the sampled sync
	assign rise = sync_d1 & ~sync_d2;
	assign fall = ~sync_d1 & sync_d2;

	////////////////////
	// Phase measurement
	////////////////////

	// Restarts on every edge, holds at CNT_MAX on a stuck sync
	always_ff @(posedge clk) begin
		if (resetd) begin
			phase_cnt <= sync_timing_pkg::CNT_RST;
		end else if (rise || fall) begin
			phase_cnt <= sync_timing_pkg::CNT_RST;
		end else begin
			phase_cnt <= sync_timing_pkg::sat_inc(phase_cnt);
		end
	end

	// A rise ends a low phase, a fall ends a high phase
	always_ff @(posedge clk) begin
		if (resetd) begin
			low_len  <= sync_timing_pkg::CNT_RST;
			high_len <= sync_timing_pkg::CNT_RST;
		end else begin
			if (rise) begin
				low_len <= sync_timing_pkg::sat_inc(phase_cnt);
			end
			if (fall) begin
				high_len <= sync_timing_pkg::sat_inc(phase_cnt);
			end
		end
	end

	////////////////////
	// Polarity flag
	////////////////////

	// Set when the high phase is the longer one, i.e. active low sync
	always_ff @(posedge clk) begin
		if (resetd) begin
			pol <= sync_timing_pkg::POL_RST;
		end else begin
			pol <= (high_len > low_len);
		end
	end

	// Raw input straight through, flipped when active low
	assign o_sync = i_sync ^ pol;

endmodule

//--- src/sync_types_pkg.sv
// Sync signal bundles
// Raw and normalized sync pair, and the conditioned output triple

package sync_types_pkg;

	////////////////////
	// Sync pair
	////////////////////

	// Horizontal and vertical sync levels
	// Polarity unknown on the raw input, active high once normalized
	typedef struct packed {
		logic hs;
		logic vs;
	} sync_pair_t;

	////////////////////
	// Output triple
	////////////////////

	// Conditioned sync as seen at the output
	//   hs  horizontal sync, or composite when enabled
	//   vs  vertical sync
	//   cs  composite sync, serrated during vsync
	typedef struct packed {
		logic hs;
		logic vs;
		logic cs;
	} sync_out_t;

	// All syncs inactive
	localparam sync_out_t SYNC_OUT_IDLE = '0;

endpackage

//--- src/sync_timing_pkg.sv
// Sync measurement timing definitions
// Counter sizing, saturation and reset values for the sync blocks

package sync_timing_pkg;

	////////////////////
	// Counter sizing
	////////////////////

	// Width of every phase and line counter
	localparam int CNT_W = 16;

	typedef logic [CNT_W-1:0] cnt_t;

	// Counters stop here instead of wrapping
	localparam cnt_t CNT_MAX = {CNT_W{1'b1}};

	////////////////////
	// Reset values
	////////////////////

	localparam cnt_t CNT_RST = '0;

	// Flag clear, so the sync passes through uninverted
	localparam logic POL_RST = 1'b0;

	////////////////////
	// Helpers
	////////////////////

	// Increment that holds at CNT_MAX
	function automatic cnt_t sat_inc(input cnt_t cnt);
		cnt_t res;
		if (cnt == CNT_MAX) begin
			res = cnt;
		end else begin
			res = cnt + 1'b1;
		end
		return res;
	endfunction

endpackage
